// ==== fds_mapper.f ====
hw/fds_pkg.sv
hw/fds_timer.sv
hw/fds_disk.sv
hw/fds_bus.sv
hw/fds_mapper.sv
tb/fds_mapper_chk.sv
tb/fds_mapper_tb.sv

// ==== hw/fds_bus.sv ====
// FDS CPU read mux and memory mapping
`timescale 1ns/1ps
`default_nettype none

module fds_bus
	import fds_pkg::*;
(
	input  cpu_addr_t    cpu_addr,
	input  logic         cpu_we,
	input  cpu_data_t    ram_rdata,
	input  logic [13:0]  ppu_addr,
	input  logic         fds_busy,
	input  logic         fds_eject,
	input  logic         timer_irq,
	input  logic         xfer_active,
	input  logic         write_active,
	input  disk_offset_t rom_offset,
	input  logic         disk_end,
	input  logic         saved,
	input  logic         mirror_vertical,
	output cpu_data_t    cpu_rdata,
	output logic         bus_drive,
	output logic         prg_allow,
	output ram_addr_t    ram_addr,
	output logic         vram_a10,
	output logic         ciram_ce
);

	logic       rd;
	logic       lo_hit;  // offset low byte peek
	logic       hi_hit;  // offset high byte peek
	logic [5:0] prg_bank;

	assign rd = ~cpu_we;

	// the BIOS sees the offset only between transfers
	assign lo_hit = rd && !xfer_active &&
		(cpu_addr == ADDR_READ_LO || cpu_addr == ADDR_WRITE_LO);
	assign hi_hit = rd && !xfer_active &&
		(cpu_addr == ADDR_READ_HI || cpu_addr == ADDR_WRITE_HI);

	always_comb begin
		cpu_rdata = ram_rdata;
		bus_drive = 1'b0;
		if (rd) begin
			bus_drive = 1'b1;
			if (cpu_addr == ADDR_IRQ_STATUS)
				cpu_rdata = {7'd0, timer_irq};
			else if (cpu_addr == ADDR_DRIVE_STATUS)
				cpu_rdata = {5'd0, fds_eject, disk_end, fds_eject};
			else if (cpu_addr == ADDR_EXT_STATUS)
				cpu_rdata = EXT_STATUS_VALUE;
			else if (cpu_addr == ADDR_SAVE_FLAG)
				cpu_rdata = {7'd0, saved};
			else if (cpu_addr == ADDR_BUSY)
				cpu_rdata = {7'd0, ~fds_busy}; // zero while busy
			else if (lo_hit)
				cpu_rdata = rom_offset[7:0];
			else if (hi_hit)
				cpu_rdata = {3'b111, rom_offset[12:8]};
			else begin
				cpu_rdata = ram_rdata;
				bus_drive = 1'b0;
			end
		end
	end

	// E000-FFFF is BIOS, or the disk image during a transfer
	always_comb begin
		if (cpu_addr[15:13] == 3'b111)
			prg_bank = xfer_active ? {1'b1, rom_offset[17:13]} : 6'd0;
		else
			prg_bank = {4'b0001, cpu_addr[14:13]}; // work RAM
	end

	assign ram_addr = {prg_bank, cpu_addr[12:0]};

	// writes to 6000-DFFF or the image, reads from 6000-FFFF
	always_comb begin
		if (cpu_we)
			prg_allow = write_active || (cpu_addr[15] ^ (&cpu_addr[14:13]));
		else
			prg_allow = (cpu_addr[15] && !lo_hit && !hi_hit) ||
				(cpu_addr[15:13] == 3'b011);
	end

	// nametables in CIRAM
	assign ciram_ce = ppu_addr[13];
	assign vram_a10 = mirror_vertical ? ppu_addr[10] : ppu_addr[11];

endmodule

`default_nettype wire

// ==== hw/fds_disk.sv ====
// FDS disk transfer tracking
`timescale 1ns/1ps
`default_nettype none

module fds_disk
	import fds_pkg::*;
#(
	parameter int SIDE_BYTES   = 65500,
	parameter int HEADER_BYTES = 16
) (
	input  logic         clk20,
	input  logic         reset,
	input  logic         strobe,
	input  cpu_addr_t    cpu_addr,
	input  logic         cpu_we,
	input  cpu_data_t    cpu_wdata,
	input  logic [1:0]   disk_side,
	output logic         xfer_active,
	output logic         write_active,
	output disk_offset_t rom_offset,
	output logic         disk_end,
	output logic         saved,
	output logic         mirror_vertical,
	output logic [1:0]   disk_side_auto
);

	localparam int POS_W = $clog2(SIDE_BYTES);
	localparam logic [POS_W-1:0] LAST_POS = POS_W'(SIDE_BYTES - 1);

	logic             disk_reset; // holds pointer at zero
	logic             write_en;
	logic [POS_W-1:0] disk_pos;
	xfer_state_e      write_state;
	xfer_state_e      read_state;

	logic         rd_strobe;
	disk_offset_t side_offset;

	// LO fetch arms, HI fetch right after it activates, anything else drops out
	function automatic xfer_state_e xfer_next(input xfer_state_e cur, input logic lo_hit,
			input logic hi_hit);
		if (lo_hit)
			return XFER_LO_SEEN;
		else if (hi_hit && cur == XFER_LO_SEEN)
			return XFER_ACTIVE;
		else
			return XFER_IDLE;
	endfunction

	assign rd_strobe = strobe & ~cpu_we;

	// control and side registers
	always_ff @(posedge clk20) begin
		if (reset) begin
			disk_reset      <= 1'b0;
			write_en        <= 1'b0;
			mirror_vertical <= 1'b0;
			disk_side_auto  <= 2'd0;
		end else if (strobe && cpu_we) begin
			if (cpu_addr == ADDR_DISK_CTRL) begin
				disk_reset      <= cpu_wdata[1];
				write_en        <= ~cpu_wdata[2]; // bit 2 set = read mode
				mirror_vertical <= ~cpu_wdata[3];
			end
			if (cpu_addr == ADDR_DISK_SIDE)
				disk_side_auto <= cpu_wdata[1:0];
		end
	end

	// detection state machines
	always_ff @(posedge clk20) begin
		if (reset) begin
			write_state <= XFER_IDLE;
			read_state  <= XFER_IDLE;
			saved       <= 1'b0;
		end else if (strobe) begin
			write_state <= xfer_next(write_state,
				rd_strobe && write_en && cpu_addr == ADDR_WRITE_LO,
				rd_strobe && cpu_addr == ADDR_WRITE_HI);
			read_state  <= xfer_next(read_state,
				rd_strobe && cpu_addr == ADDR_READ_LO,
				rd_strobe && cpu_addr == ADDR_READ_HI);
			if (write_state == XFER_ACTIVE)
				saved <= 1'b1; // sticky until reset
		end
	end

	// byte pointer within the side
	always_ff @(posedge clk20) begin
		if (reset)
			disk_pos <= '0;
		else if (strobe) begin
			if (disk_reset)
				disk_pos <= '0;
			else if (read_state == XFER_ACTIVE && !disk_end)
				disk_pos <= disk_pos + POS_W'(1);
		end
	end

	assign disk_end     = (disk_pos == LAST_POS);
	assign xfer_active  = (read_state == XFER_ACTIVE) || (write_state == XFER_ACTIVE);
	assign write_active = (write_state == XFER_ACTIVE);

	// header first, then the sides back to back
	assign side_offset = disk_offset_t'(disk_side) * disk_offset_t'(SIDE_BYTES);
	assign rom_offset  = disk_offset_t'(disk_pos) + disk_offset_t'(HEADER_BYTES) + side_offset;

endmodule

`default_nettype wire

// ==== hw/fds_mapper.sv ====
// FDS mapper top level
`timescale 1ns/1ps
`default_nettype none

module fds_mapper
	import fds_pkg::*;
#(
	parameter int SIDE_BYTES   = 65500,
	parameter int HEADER_BYTES = 16
) (
	input  logic        clk20,
	input  logic        reset,
	input  logic        strobe,       // CPU cycle
	input  cpu_addr_t   cpu_addr,
	input  logic        cpu_we,
	input  cpu_data_t   cpu_wdata,
	input  cpu_data_t   ram_rdata,
	input  logic [13:0] ppu_addr,
	input  logic [1:0]  disk_side,
	input  logic        fds_busy,
	input  logic        fds_eject,
	output cpu_data_t   cpu_rdata,
	output logic        bus_drive,
	output logic        prg_allow,
	output ram_addr_t   ram_addr,
	output logic        vram_a10,
	output logic        ciram_ce,
	output logic        irq,
	output logic [1:0]  disk_side_auto
);

	logic         xfer_active;
	logic         write_active;
	disk_offset_t rom_offset;
	logic         disk_end;
	logic         saved;
	logic         mirror_vertical;

	fds_timer u_timer (
		.clk20     (clk20),
		.reset     (reset),
		.strobe    (strobe),
		.cpu_addr  (cpu_addr),
		.cpu_we    (cpu_we),
		.cpu_wdata (cpu_wdata),
		.timer_irq (irq)
	);

	fds_disk #(
		.SIDE_BYTES   (SIDE_BYTES),
		.HEADER_BYTES (HEADER_BYTES)
	) u_disk (
		.clk20           (clk20),
		.reset           (reset),
		.strobe          (strobe),
		.cpu_addr        (cpu_addr),
		.cpu_we          (cpu_we),
		.cpu_wdata       (cpu_wdata),
		.disk_side       (disk_side),
		.xfer_active     (xfer_active),
		.write_active    (write_active),
		.rom_offset      (rom_offset),
		.disk_end        (disk_end),
		.saved           (saved),
		.mirror_vertical (mirror_vertical),
		.disk_side_auto  (disk_side_auto)
	);

	fds_bus u_bus (
		.cpu_addr        (cpu_addr),
		.cpu_we          (cpu_we),
		.ram_rdata       (ram_rdata),
		.ppu_addr        (ppu_addr),
		.fds_busy        (fds_busy),
		.fds_eject       (fds_eject),
		.timer_irq       (irq),
		.xfer_active     (xfer_active),
		.write_active    (write_active),
		.rom_offset      (rom_offset),
		.disk_end        (disk_end),
		.saved           (saved),
		.mirror_vertical (mirror_vertical),
		.cpu_rdata       (cpu_rdata),
		.bus_drive       (bus_drive),
		.prg_allow       (prg_allow),
		.ram_addr        (ram_addr),
		.vram_a10        (vram_a10),
		.ciram_ce        (ciram_ce)
	);

endmodule

`default_nettype wire

// ==== hw/fds_pkg.sv ====
// FDS mapper shared definitions
`default_nettype none

package fds_pkg;

	// bus and memory widths
	localparam int CPU_ADDR_W    = 16;
	localparam int CPU_DATA_W    = 8;
	localparam int RAM_ADDR_W    = 19; // 512k external RAM
	localparam int DISK_OFFSET_W = 18; // up to four sides plus header

	typedef logic [CPU_ADDR_W-1:0]    cpu_addr_t;
	typedef logic [CPU_DATA_W-1:0]    cpu_data_t;
	typedef logic [RAM_ADDR_W-1:0]    ram_addr_t;
	typedef logic [DISK_OFFSET_W-1:0] disk_offset_t;

	// read/write detection sequence
	typedef enum logic [1:0] {
		XFER_IDLE    = 2'd0,
		XFER_LO_SEEN = 2'd1,
		XFER_ACTIVE  = 2'd2
	} xfer_state_e;

	// timer and I/O registers
	localparam cpu_addr_t ADDR_TIMER_LO   = 16'h4020;
	localparam cpu_addr_t ADDR_TIMER_HI   = 16'h4021;
	localparam cpu_addr_t ADDR_TIMER_CTRL = 16'h4022;
	localparam cpu_addr_t ADDR_IO_ENABLE  = 16'h4023;

	// disk control and status
	localparam cpu_addr_t ADDR_DISK_CTRL    = 16'h4025;
	localparam cpu_addr_t ADDR_DISK_SIDE    = 16'h4027; // auto side select
	localparam cpu_addr_t ADDR_BUSY         = 16'h4029;
	localparam cpu_addr_t ADDR_IRQ_STATUS   = 16'h4030; // read acks timer irq
	localparam cpu_addr_t ADDR_DRIVE_STATUS = 16'h4032;
	localparam cpu_addr_t ADDR_EXT_STATUS   = 16'h4033;
	localparam cpu_addr_t ADDR_SAVE_FLAG    = 16'h4208;

	// BIOS fetch addresses that mark a disk byte transfer
	localparam cpu_addr_t ADDR_WRITE_LO = 16'hF4CD;
	localparam cpu_addr_t ADDR_WRITE_HI = 16'hF4CE;
	localparam cpu_addr_t ADDR_READ_LO  = 16'hF4D0;
	localparam cpu_addr_t ADDR_READ_HI  = 16'hF4D1;

	// battery good, expansion port idle
	localparam cpu_data_t EXT_STATUS_VALUE = 8'h80;

endpackage

`default_nettype wire

// ==== hw/fds_timer.sv ====
// FDS timer interrupt
`timescale 1ns/1ps
`default_nettype none

module fds_timer
	import fds_pkg::*;
(
	input  logic      clk20,
	input  logic      reset,
	input  logic      strobe,    // one pulse per CPU cycle
	input  cpu_addr_t cpu_addr,
	input  logic      cpu_we,
	input  cpu_data_t cpu_wdata,
	output logic      timer_irq
);

	logic [15:0] timer_latch; // reload value
	logic [15:0] timer_count;
	logic        timer_en;
	logic        timer_repeat;
	logic        io_en;        // $4023 bit 0

	logic        wr_strobe;
	logic        enable_write;

	assign wr_strobe = strobe & cpu_we;

	// a $4022 write only starts the timer while I/O is on
	assign enable_write = cpu_wdata[1] & io_en;

	// reload latch
	always_ff @(posedge clk20) begin
		if (wr_strobe) begin
			if (cpu_addr == ADDR_TIMER_LO)
				timer_latch[7:0] <= cpu_wdata;
			if (cpu_addr == ADDR_TIMER_HI)
				timer_latch[15:8] <= cpu_wdata;
		end
	end

	always_ff @(posedge clk20) begin
		if (reset) begin
			timer_en     <= 1'b0;
			timer_repeat <= 1'b0;
			io_en        <= 1'b0;
			timer_irq    <= 1'b0;
		end else if (strobe) begin
			if (timer_en) begin
				if (timer_count == 16'd0) begin
					timer_irq   <= 1'b1;
					timer_count <= timer_latch;
					if (!timer_repeat)
						timer_en <= 1'b0; // one-shot
				end else begin
					timer_count <= timer_count - 16'd1;
				end
			end

			if (cpu_we) begin
				case (cpu_addr)
					ADDR_TIMER_CTRL: begin
						timer_repeat <= cpu_wdata[0];
						timer_en     <= enable_write;
						if (enable_write)
							timer_count <= timer_latch;
						else
							timer_irq <= 1'b0;
					end
					ADDR_IO_ENABLE: begin
						io_en <= cpu_wdata[0];
						if (!cpu_wdata[0]) begin
							timer_en  <= 1'b0;
							timer_irq <= 1'b0;
						end
					end
					default: ;
				endcase
			end else if (cpu_addr == ADDR_IRQ_STATUS) begin
				timer_irq <= 1'b0; // status read acknowledges
			end
		end
	end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the FDS mapper testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=fds_mapper_tb
LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator not found"
	exit 1
fi

verilator --binary --timing --assert --top-module "$TOP" -f fds_mapper.f
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

./obj_dir/V$TOP > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi

// ==== tb/fds_mapper_chk.sv ====
// FDS mapper bus assertions
`timescale 1ns/1ps
`default_nettype none

module fds_mapper_chk
	import fds_pkg::*;
(
	input logic        clk20,
	input logic        reset,
	input logic        strobe,
	input cpu_addr_t   cpu_addr,
	input logic        cpu_we,
	input logic        bus_drive,
	input logic        irq,
	input logic [13:0] ppu_addr,
	input logic        ciram_ce
);

	logic        decoded;        // addresses that may drive the bus
	int unsigned fail_count = 0; // assertion failures so far

	assign decoded = cpu_addr inside {ADDR_BUSY, ADDR_IRQ_STATUS, ADDR_DRIVE_STATUS,
		ADDR_EXT_STATUS, ADDR_SAVE_FLAG, ADDR_WRITE_LO, ADDR_WRITE_HI,
		ADDR_READ_LO, ADDR_READ_HI};

	irq_ack: assert property (@(posedge clk20) disable iff (reset)
		(strobe && !cpu_we && cpu_addr == ADDR_IRQ_STATUS) |=> !irq)
		else begin
			fail_count++;
			$error("irq still high after a status read");
		end

	quiet_bus: assert property (@(posedge clk20) disable iff (reset)
		!decoded |-> !bus_drive)
		else begin
			fail_count++;
			$error("bus driven for an undecoded address");
		end

	// CIRAM select is plain PPU A13
	ciram_sel: assert property (@(posedge clk20) ciram_ce == ppu_addr[13])
		else begin
			fail_count++;
			$error("ciram_ce differs from PPU address bit 13");
		end

endmodule

bind fds_mapper fds_mapper_chk u_chk (.*);

`default_nettype wire

// ==== tb/fds_mapper_tb.sv ====
// FDS mapper testbench
`timescale 1ns/1ps
`default_nettype none

module fds_mapper_tb
	import fds_pkg::*;
();

	localparam int SIDE_BYTES   = 65500;
	localparam int HEADER_BYTES = 16;
	localparam int TIMER_N      = 3;
	localparam int XFER_BYTES   = 3;

	typedef struct {
		logic        we;
		cpu_addr_t   addr;
		cpu_data_t   wdata;
		int          strobes;
		cpu_data_t   ram_in;
		logic [13:0] ppu_in;
		logic        busy_in;
		logic        eject_in;
		cpu_data_t   exp_rdata;
		logic        exp_drive;
		ram_addr_t   exp_ram;
		logic        exp_allow;
		logic        exp_vertical;
		logic [1:0]  exp_side_auto;
		logic        exp_irq;      // after the last strobe
	} row_t;

	logic        clk20 = 1'b0;
	logic        reset;
	logic        strobe;
	cpu_addr_t   cpu_addr;
	logic        cpu_we;
	cpu_data_t   cpu_wdata;
	cpu_data_t   ram_rdata;
	logic [13:0] ppu_addr;
	logic [1:0]  disk_side;
	logic        fds_busy;
	logic        fds_eject;
	cpu_data_t   cpu_rdata;
	logic        bus_drive;
	logic        prg_allow;
	ram_addr_t   ram_addr;
	logic        vram_a10;
	logic        ciram_ce;
	logic        irq;
	logic [1:0]  disk_side_auto;

	row_t        rows[$];
	logic [15:0] lfsr_state = 16'd83;
	int          cycle_count = 0;

	// expected register state while rows are added
	logic        m_active;
	logic        m_wactive;
	logic        m_vertical;
	logic [1:0]  m_side_auto;
	logic        m_busy;
	logic        m_eject;
	int          m_pos;
	logic [1:0]  side;

	fds_mapper #(
		.SIDE_BYTES   (SIDE_BYTES),
		.HEADER_BYTES (HEADER_BYTES)
	) UUT (.*);

	always #4 clk20 = ~clk20;

	always @(posedge clk20) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > rows.size() * 4 + 200)
			fail_stop("timeout: the stimulus table did not finish");
		else if (UUT.u_chk.fail_count != 0)
			fail_stop("a bus assertion failed");
	end

	task automatic fail_stop(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check_data(input string name, input cpu_data_t got, input cpu_data_t exp);
		if (got !== exp)
			fail_stop($sformatf("mismatch at %0t: %s is %h, expected %h",
				$time, name, got, exp));
	endtask

	task automatic check_addr(input string name, input ram_addr_t got, input ram_addr_t exp);
		if (got !== exp)
			fail_stop($sformatf("mismatch at %0t: %s is %h, expected %h",
				$time, name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_stop($sformatf("mismatch at %0t: %s is %b, expected %b",
				$time, name, got, exp));
	endtask

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [15:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[14:0], lfsr_state[0]};
		end
	endtask

	// header first, then whole sides
	function automatic disk_offset_t image_offset(input int pos);
		return disk_offset_t'(HEADER_BYTES + int'(side) * SIDE_BYTES + pos);
	endfunction

	function automatic ram_addr_t expect_ram_addr(input cpu_addr_t a);
		disk_offset_t off;
		off = image_offset(m_pos);
		if (a >= 16'hE000)
			return m_active ? {1'b1, off[17:13], a[12:0]} : {6'd0, a[12:0]};
		return {4'b0001, a[14:13], a[12:0]};
	endfunction

	task automatic add_row(input logic we, input cpu_addr_t a, input cpu_data_t wdata,
			input int strobes, input logic drive, input cpu_data_t rdata, input logic irq_after);
		row_t        r;
		logic [15:0] rnd;
		logic        reg_peek;
		take_bits(8, rnd);
		r.ram_in = rnd[7:0];
		take_bits(14, rnd);
		r.ppu_in = rnd[13:0];
		r.we = we;
		r.addr = a;
		r.wdata = wdata;
		r.strobes = strobes;
		r.busy_in = m_busy;
		r.eject_in = m_eject;
		r.exp_rdata = drive ? rdata : r.ram_in; // undecoded reads pass RAM through
		r.exp_drive = drive;
		r.exp_ram = expect_ram_addr(a);
		reg_peek = drive && (a inside {ADDR_READ_LO, ADDR_READ_HI, ADDR_WRITE_LO, ADDR_WRITE_HI});
		if (we)
			r.exp_allow = (a >= 16'h6000 && a < 16'hE000) || m_wactive;
		else
			r.exp_allow = (a >= 16'h6000) && !reg_peek;
		r.exp_vertical = m_vertical;
		r.exp_side_auto = m_side_auto;
		r.exp_irq = irq_after;
		rows.push_back(r);
		if (we && a == ADDR_DISK_CTRL)
			m_vertical = ~wdata[3];
		if (we && a == ADDR_DISK_SIDE)
			m_side_auto = wdata[1:0];
	endtask

	task automatic build_table();
		disk_offset_t off;
		logic [15:0]  rnd;
		int           k;
		take_bits(2, rnd);
		side = rnd[1:0];
		m_active = 1'b0;
		m_wactive = 1'b0;
		m_vertical = 1'b0;
		m_side_auto = 2'd0;
		m_busy = 1'b0;
		m_eject = 1'b0;
		m_pos = 0;

		add_row(1'b0, 16'hE000, 8'h00, 1, 1'b0, 8'h00, 1'b0); // BIOS bank after reset

		// one-shot timer
		add_row(1'b1, ADDR_TIMER_LO, 8'(TIMER_N), 1, 1'b0, 8'h00, 1'b0);
		add_row(1'b1, ADDR_TIMER_HI, 8'h00, 1, 1'b0, 8'h00, 1'b0);
		add_row(1'b1, ADDR_IO_ENABLE, 8'h01, 1, 1'b0, 8'h00, 1'b0);
		add_row(1'b1, ADDR_TIMER_CTRL, 8'h02, 1, 1'b0, 8'h00, 1'b0);
		add_row(1'b0, 16'h6000, 8'h00, TIMER_N, 1'b0, 8'h00, 1'b0);
		add_row(1'b0, 16'h6000, 8'h00, 1, 1'b0, 8'h00, 1'b1);
		add_row(1'b0, ADDR_IRQ_STATUS, 8'h00, 1, 1'b1, 8'h01, 1'b0);

		// disk read after a pointer reset, then the LO/HI fetch pairs
		add_row(1'b1, ADDR_DISK_CTRL, 8'h06, 1, 1'b0, 8'h00, 1'b0);
		add_row(1'b1, ADDR_DISK_CTRL, 8'h04, 1, 1'b0, 8'h00, 1'b0);
		off = image_offset(m_pos);
		add_row(1'b0, ADDR_READ_LO, 8'h00, 1, 1'b1, off[7:0], 1'b0);
		add_row(1'b0, ADDR_READ_HI, 8'h00, 1, 1'b1, {3'b111, off[12:8]}, 1'b0);
		m_active = 1'b1;
		for (k = 0; k < XFER_BYTES; k++) begin
			add_row(1'b0, ADDR_READ_LO, 8'h00, 1, 1'b0, 8'h00, 1'b0); // byte from the image
			m_active = 1'b0;
			m_pos++;
			off = image_offset(m_pos);
			add_row(1'b0, ADDR_READ_HI, 8'h00, 1, 1'b1, {3'b111, off[12:8]}, 1'b0);
			m_active = 1'b1;
		end
		add_row(1'b0, 16'h6000, 8'h00, 1, 1'b0, 8'h00, 1'b0); // ends the transfer
		m_active = 1'b0;
		m_pos++;
		off = image_offset(m_pos);
		add_row(1'b0, ADDR_READ_LO, 8'h00, 1, 1'b1, off[7:0], 1'b0);
		add_row(1'b0, ADDR_READ_HI, 8'h00, 1, 1'b1, {3'b111, off[12:8]}, 1'b0);
		m_active = 1'b1;
		add_row(1'b0, 16'hE000, 8'h00, 1, 1'b0, 8'h00, 1'b0);
		m_active = 1'b0;
		m_pos++;

		// disk write marks the image saved
		add_row(1'b1, ADDR_DISK_CTRL, 8'h00, 1, 1'b0, 8'h00, 1'b0);
		off = image_offset(m_pos);
		add_row(1'b0, ADDR_WRITE_LO, 8'h00, 1, 1'b1, off[7:0], 1'b0);
		add_row(1'b0, ADDR_WRITE_HI, 8'h00, 1, 1'b1, {3'b111, off[12:8]}, 1'b0);
		m_active = 1'b1;
		m_wactive = 1'b1;
		add_row(1'b1, 16'hE000, 8'h5A, 1, 1'b0, 8'h00, 1'b0);
		m_active = 1'b0;
		m_wactive = 1'b0;
		add_row(1'b1, 16'hE000, 8'hA5, 1, 1'b0, 8'h00, 1'b0); // BIOS stays read-only
		add_row(1'b0, ADDR_SAVE_FLAG, 8'h00, 1, 1'b1, 8'h01, 1'b0);

		// status inputs, side select and mirroring
		add_row(1'b0, ADDR_EXT_STATUS, 8'h00, 1, 1'b1, 8'h80, 1'b0);
		m_eject = 1'b1;
		add_row(1'b0, ADDR_DRIVE_STATUS, 8'h00, 1, 1'b1, 8'h05, 1'b0);
		add_row(1'b0, ADDR_BUSY, 8'h00, 1, 1'b1, 8'h01, 1'b0);
		m_eject = 1'b0;
		m_busy = 1'b1;
		add_row(1'b0, ADDR_DRIVE_STATUS, 8'h00, 1, 1'b1, 8'h00, 1'b0);
		add_row(1'b0, ADDR_BUSY, 8'h00, 1, 1'b1, 8'h00, 1'b0);
		m_busy = 1'b0;
		take_bits(2, rnd);
		add_row(1'b1, ADDR_DISK_SIDE, {6'd0, rnd[1:0]}, 1, 1'b0, 8'h00, 1'b0);
		add_row(1'b0, 16'h0000, 8'h00, 1, 1'b0, 8'h00, 1'b0);
		add_row(1'b1, ADDR_DISK_SIDE, {6'd0, ~rnd[1:0]}, 1, 1'b0, 8'h00, 1'b0); // both bits flip
		add_row(1'b1, ADDR_DISK_CTRL, 8'h08, 1, 1'b0, 8'h00, 1'b0); // horizontal
		for (k = 0; k < 3; k++)
			add_row(1'b0, 16'h0000, 8'h00, 1, 1'b0, 8'h00, 1'b0);
	endtask

	task automatic apply_row(input row_t r);
		int s;
		@(posedge clk20);
		cpu_addr  <= r.addr;
		cpu_we    <= r.we;
		cpu_wdata <= r.wdata;
		ram_rdata <= r.ram_in;
		ppu_addr  <= r.ppu_in;
		fds_busy  <= r.busy_in;
		fds_eject <= r.eject_in;
		strobe    <= 1'b1;
		@(negedge clk20);
		check_data("cpu_rdata", cpu_rdata, r.exp_rdata);
		check_bit("bus_drive", bus_drive, r.exp_drive);
		check_addr("ram_addr", ram_addr, r.exp_ram);
		check_bit("prg_allow", prg_allow, r.exp_allow);
		check_bit("ciram_ce", ciram_ce, r.ppu_in[13]);
		check_bit("vram_a10", vram_a10, r.exp_vertical ? r.ppu_in[10] : r.ppu_in[11]);
		check_data("disk_side_auto", {6'd0, disk_side_auto}, {6'd0, r.exp_side_auto});
		for (s = 1; s < r.strobes; s++) begin
			@(posedge clk20);
			strobe <= 1'b0;
			@(posedge clk20);
			strobe <= 1'b1;
		end
		@(posedge clk20);
		strobe <= 1'b0; // last strobe taken at this edge
		@(negedge clk20);
		check_bit("irq", irq, r.exp_irq);
	endtask

	initial begin
		build_table();
		reset     <= 1'b1;
		strobe    <= 1'b0;
		cpu_addr  <= '0;
		cpu_we    <= 1'b0;
		cpu_wdata <= '0;
		ram_rdata <= '0;
		ppu_addr  <= '0;
		disk_side <= side;
		fds_busy  <= 1'b0;
		fds_eject <= 1'b0;
		repeat (4) @(posedge clk20);
		reset <= 1'b0;
		foreach (rows[i])
			apply_row(rows[i]);
		if (UUT.u_chk.fail_count != 0)
			fail_stop("a bus assertion failed");
		else begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule

`default_nettype wire
